// ==== src/controlPkg.sv ====
package controlPkg;

  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;

  // Opcodes
  localparam opcodeT opR   = 6'h00;
  localparam opcodeT opJ   = 6'h02;
  localparam opcodeT opJal = 6'h03;

  // R-type funct field
  localparam functT fnAdd   = 6'h20;
  localparam functT fnAnd   = 6'h24;
  localparam functT fnSub   = 6'h22;
  localparam functT fnSlt   = 6'h2a;
  localparam functT fnSrav  = 6'h07;
  localparam functT fnSllv  = 6'h04;
  localparam functT fnSll   = 6'h00;
  localparam functT fnSra   = 6'h03;
  localparam functT fnSrl   = 6'h02;
  localparam functT fnJr    = 6'h08;
  localparam functT fnMfhi  = 6'h10;
  localparam functT fnMflo  = 6'h12;
  localparam functT fnRte   = 6'h13;
  localparam functT fnBreak = 6'h0d;

  typedef enum logic [3:0] {
    aluPassA    = 4'b0000,
    aluAdd      = 4'b0001,
    aluSub      = 4'b0010,
    aluAnd      = 4'b0011,
    aluShiftL1  = 4'b0101,  // Shift amount from shamt
    aluShiftL2  = 4'b0110,  // Shift amount from rs
    aluShiftR   = 4'b0111,
    aluShiftRa1 = 4'b1000,
    aluShiftRa2 = 4'b1001,
    aluSlt      = 4'b1010
  } aluOpT;

  typedef enum logic [3:0] {
    clsNone, clsAluReg, clsShiftVar, clsShiftImm, clsJr,
    clsMoveHiLo, clsBreak, clsJump, clsJal, clsRte
  } instrClassT;

  typedef enum logic [1:0] {phReset, phFetch, phExecute} phaseT;
  typedef logic [2:0] stepT;

  // Fetch steps are right aligned so the PC write always lands here
  localparam stepT fetchLastStep = 3'd3;

  typedef enum logic [1:0] {
    pcFromAlu = 2'b00, pcFromAluOut = 2'b01, pcFromJump = 2'b10, pcFromEpc = 2'b11
  } pcSrcSelT;

  typedef enum logic [1:0] {dstRt = 2'b00, dstRd = 2'b01, dstRa = 2'b11} regDstSelT;

  typedef enum logic [2:0] {
    dataAluOut = 3'b000, dataHi = 3'b011, dataLo = 3'b100
  } regDataSelT;

  typedef enum logic [1:0] {srcPcOrB = 2'b00, srcRegOrFour = 2'b01} aluSrcSelT;

endpackage

// ==== src/instrClassRegister.sv ====
`timescale 1ns/1ps

module instrClassRegister (
  input  logic                   clk,
  input  logic                   reset_in,
  input  logic                   decodeStrobe,
  input  controlPkg::opcodeT     opcode,
  input  controlPkg::functT      funct,
  output controlPkg::instrClassT instrClass,
  output controlPkg::functT      latchedFunct
);

  controlPkg::instrClassT decodedClass;
  controlPkg::instrClassT classReg;
  controlPkg::functT      functReg;

  always_comb begin
    decodedClass = controlPkg::clsNone;
    if (opcode == controlPkg::opJ) begin
      decodedClass = controlPkg::clsJump;
    end else if (opcode == controlPkg::opJal) begin
      decodedClass = controlPkg::clsJal;
    end else if (opcode == controlPkg::opR) begin
      case (funct)
        controlPkg::fnAdd, controlPkg::fnAnd,
        controlPkg::fnSub, controlPkg::fnSlt:   decodedClass = controlPkg::clsAluReg;
        controlPkg::fnSrav, controlPkg::fnSllv: decodedClass = controlPkg::clsShiftVar;
        controlPkg::fnSll, controlPkg::fnSra,
        controlPkg::fnSrl:                      decodedClass = controlPkg::clsShiftImm;
        controlPkg::fnJr:                       decodedClass = controlPkg::clsJr;
        controlPkg::fnMfhi, controlPkg::fnMflo: decodedClass = controlPkg::clsMoveHiLo;
        controlPkg::fnBreak:                    decodedClass = controlPkg::clsBreak;
        controlPkg::fnRte:                      decodedClass = controlPkg::clsRte;
        default:                                decodedClass = controlPkg::clsNone;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      classReg <= controlPkg::clsNone;
    end else if (decodeStrobe) begin
      classReg <= decodedClass;
    end
  end

  always_ff @(posedge clk) begin
    if (decodeStrobe) functReg <= funct;
  end

  // Forwarded during decode so a zero-wait fetch already sees the new class
  assign instrClass   = decodeStrobe ? decodedClass : classReg;
  assign latchedFunct = decodeStrobe ? funct : functReg;

endmodule

// ==== src/microSequencer.sv ====
`timescale 1ns/1ps

module microSequencer #(
  parameter int memWaitCycles   = 1,
  parameter int shiftWaitCycles = 1
) (
  input  logic                   clk,
  input  logic                   reset_in,
  input  controlPkg::instrClassT instrClass,
  output controlPkg::phaseT      phase,
  output controlPkg::stepT       step,
  output controlPkg::phaseT      nextPhase,
  output controlPkg::stepT       nextStep,
  output logic                   decodeStrobe
);

  // Step after fetch step 0, skipping unused wait slots
  localparam controlPkg::stepT fetchSecondStep =
    3'(controlPkg::fetchLastStep - memWaitCycles);

  logic [3:0] execLen;

  function automatic logic [3:0] execLength(input controlPkg::instrClassT cls);
    logic [3:0] len;
    case (cls)
      controlPkg::clsAluReg,
      controlPkg::clsShiftImm,
      controlPkg::clsJr,
      controlPkg::clsBreak:    len = 4'd5;
      controlPkg::clsShiftVar: len = 4'(5 + shiftWaitCycles);  // Shifter settles longer
      controlPkg::clsMoveHiLo,
      controlPkg::clsJal:      len = 4'd2;
      default:                 len = 4'd0;  // j, rte and unsupported
    endcase
    return len;
  endfunction

  assign execLen = execLength(instrClass);

  always_comb begin
    nextPhase = phase;
    nextStep  = step + 3'd1;
    case (phase)
      controlPkg::phReset: begin
        // Hold one extra cycle after reset drops
        if (step != '0) begin
          nextPhase = controlPkg::phFetch;
          nextStep  = '0;
        end
      end
      controlPkg::phFetch: begin
        if (step == '0) begin
          nextStep = fetchSecondStep;
        end else if (step == controlPkg::fetchLastStep) begin
          nextStep = '0;
          if (execLen == 4'd0) begin
            nextPhase = controlPkg::phFetch;
          end else begin
            nextPhase = controlPkg::phExecute;
          end
        end
      end
      controlPkg::phExecute: begin
        if ({1'b0, step} == execLen - 4'd1) begin
          nextPhase = controlPkg::phFetch;
          nextStep  = '0;
        end
      end
      default: begin
        nextPhase = controlPkg::phReset;
        nextStep  = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase <= controlPkg::phReset;
      step  <= '0;
    end else begin
      phase <= nextPhase;
      step  <= nextStep;
    end
  end

  assign decodeStrobe = (phase == controlPkg::phFetch) && (step == '0);

endmodule

// ==== src/controlSignalRegister.sv ====
`timescale 1ns/1ps

module controlSignalRegister #(
  parameter int shiftWaitCycles = 1
) (
  input  logic                   clk,
  input  logic                   reset_in,
  input  controlPkg::phaseT      nextPhase,
  input  controlPkg::stepT       nextStep,
  input  controlPkg::instrClassT instrClass,
  input  controlPkg::functT      latchedFunct,
  output logic                   resetOut,
  output logic                   pcWrite,
  output logic                   irWrite,
  output logic                   aluOutWrite,
  output logic                   regFileWrite,
  output logic                   aRegWrite,
  output logic                   bRegWrite,
  output controlPkg::pcSrcSelT   pcSrcSel,
  output controlPkg::regDstSelT  regDstSel,
  output controlPkg::regDataSelT regDataSel,
  output controlPkg::aluSrcSelT  aluSrcASel,
  output controlPkg::aluSrcSelT  aluSrcBSel,
  output controlPkg::aluOpT      aluOp
);

  localparam controlPkg::stepT writeStep         = 3'd2;
  localparam controlPkg::stepT shiftVarWriteStep = 3'(2 + shiftWaitCycles);

  logic nResetOut, nPcWrite, nIrWrite, nAluOutWrite;
  logic nRegFileWrite, nARegWrite, nBRegWrite;
  controlPkg::pcSrcSelT   nPcSrcSel;
  controlPkg::regDstSelT  nRegDstSel;
  controlPkg::regDataSelT nRegDataSel;
  controlPkg::aluSrcSelT  nAluSrcASel, nAluSrcBSel;
  controlPkg::aluOpT      nAluOp;

  function automatic controlPkg::aluOpT functAluOp(input controlPkg::instrClassT cls,
                                                   input controlPkg::functT fn);
    controlPkg::aluOpT op;
    op = controlPkg::aluPassA;
    case (cls)
      controlPkg::clsAluReg: begin
        case (fn)
          controlPkg::fnAdd: op = controlPkg::aluAdd;
          controlPkg::fnAnd: op = controlPkg::aluAnd;
          controlPkg::fnSub: op = controlPkg::aluSub;
          controlPkg::fnSlt: op = controlPkg::aluSlt;
          default:           op = controlPkg::aluPassA;
        endcase
      end
      controlPkg::clsShiftVar: begin
        if (fn == controlPkg::fnSrav) op = controlPkg::aluShiftRa2;
        else                          op = controlPkg::aluShiftL2;
      end
      controlPkg::clsShiftImm: begin
        case (fn)
          controlPkg::fnSll: op = controlPkg::aluShiftL1;
          controlPkg::fnSra: op = controlPkg::aluShiftRa1;
          controlPkg::fnSrl: op = controlPkg::aluShiftR;
          default:           op = controlPkg::aluPassA;
        endcase
      end
      default: op = controlPkg::aluPassA;
    endcase
    return op;
  endfunction

  always_comb begin
    nResetOut     = 1'b0;
    nPcWrite      = 1'b0;
    nIrWrite      = 1'b0;
    nAluOutWrite  = 1'b0;
    nRegFileWrite = 1'b0;
    nARegWrite    = 1'b0;
    nBRegWrite    = 1'b0;
    nPcSrcSel     = controlPkg::pcFromAlu;
    nRegDstSel    = controlPkg::dstRt;
    nRegDataSel   = controlPkg::dataAluOut;
    nAluSrcASel   = controlPkg::srcPcOrB;
    nAluSrcBSel   = controlPkg::srcPcOrB;
    nAluOp        = controlPkg::aluPassA;
    case (nextPhase)
      controlPkg::phReset: nResetOut = 1'b1;
      controlPkg::phFetch: begin
        if (nextStep == controlPkg::fetchLastStep) begin
          nPcWrite = 1'b1;
          case (instrClass)
            controlPkg::clsJump, controlPkg::clsJal: nPcSrcSel = controlPkg::pcFromJump;
            controlPkg::clsRte:                      nPcSrcSel = controlPkg::pcFromEpc;
            default:                                 nPcSrcSel = controlPkg::pcFromAluOut;
          endcase
          if (instrClass == controlPkg::clsMoveHiLo) begin
            nRegFileWrite = 1'b1;
            nRegDstSel    = controlPkg::dstRd;
            if (latchedFunct == controlPkg::fnMfhi) nRegDataSel = controlPkg::dataHi;
            else                                    nRegDataSel = controlPkg::dataLo;
          end
          if (instrClass == controlPkg::clsJal) nRegDstSel = controlPkg::dstRa;
        end else begin
          // PC+4 into ALUOut, selects held through the memory wait
          nIrWrite     = (nextStep == '0);
          nAluOutWrite = (nextStep == '0);
          nAluSrcBSel  = controlPkg::srcRegOrFour;
          nAluOp       = controlPkg::aluAdd;
          nPcSrcSel    = controlPkg::pcFromAluOut;
        end
      end
      controlPkg::phExecute: begin
        case (instrClass)
          controlPkg::clsAluReg, controlPkg::clsShiftVar: begin
            nRegDstSel = controlPkg::dstRd;
            if (nextStep == '0) begin
              nARegWrite = 1'b1;
              nBRegWrite = 1'b1;
            end else begin
              nAluSrcASel = controlPkg::srcRegOrFour;
              nAluOp      = functAluOp(instrClass, latchedFunct);
            end
            if (instrClass == controlPkg::clsShiftVar) begin
              nRegFileWrite = (nextStep == shiftVarWriteStep);
            end else begin
              nRegFileWrite = (nextStep == writeStep);
            end
          end
          controlPkg::clsShiftImm: begin
            nRegDstSel    = controlPkg::dstRd;
            nBRegWrite    = (nextStep == '0);
            nRegFileWrite = (nextStep == writeStep);
            if (nextStep != '0) nAluOp = functAluOp(instrClass, latchedFunct);
          end
          controlPkg::clsJr: begin
            // ALU passes A through, PC taken from the ALU
            nRegDstSel = controlPkg::dstRd;
            nARegWrite = (nextStep == '0);
            if (nextStep != '0) nAluSrcASel = controlPkg::srcRegOrFour;
            nPcWrite   = (nextStep == writeStep);
          end
          controlPkg::clsBreak: begin
            // Back the PC up by four
            nRegDstSel   = controlPkg::dstRd;
            nAluSrcBSel  = controlPkg::srcRegOrFour;
            nAluOp       = controlPkg::aluSub;
            nPcSrcSel    = controlPkg::pcFromAluOut;
            nAluOutWrite = (nextStep == '0);
            nPcWrite     = (nextStep == writeStep);
          end
          controlPkg::clsMoveHiLo: nRegDstSel = controlPkg::dstRd;
          controlPkg::clsJal: begin
            nRegDstSel    = controlPkg::dstRa;
            nRegFileWrite = (nextStep == '0);  // Return address into $ra
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      resetOut     <= 1'b1;
      pcWrite      <= 1'b0;
      irWrite      <= 1'b0;
      aluOutWrite  <= 1'b0;
      regFileWrite <= 1'b0;
      aRegWrite    <= 1'b0;
      bRegWrite    <= 1'b0;
      pcSrcSel     <= controlPkg::pcFromAlu;
      regDstSel    <= controlPkg::dstRt;
      regDataSel   <= controlPkg::dataAluOut;
      aluSrcASel   <= controlPkg::srcPcOrB;
      aluSrcBSel   <= controlPkg::srcPcOrB;
      aluOp        <= controlPkg::aluPassA;
    end else begin
      resetOut     <= nResetOut;
      pcWrite      <= nPcWrite;
      irWrite      <= nIrWrite;
      aluOutWrite  <= nAluOutWrite;
      regFileWrite <= nRegFileWrite;
      aRegWrite    <= nARegWrite;
      bRegWrite    <= nBRegWrite;
      pcSrcSel     <= nPcSrcSel;
      regDstSel    <= nRegDstSel;
      regDataSel   <= nRegDataSel;
      aluSrcASel   <= nAluSrcASel;
      aluSrcBSel   <= nAluSrcBSel;
      aluOp        <= nAluOp;
    end
  end

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit #(
  parameter int memWaitCycles   = 1,  // 0 to 2
  parameter int shiftWaitCycles = 1   // 0 to 2
) (
  input  logic                   clk,
  input  logic                   reset_in,
  input  controlPkg::opcodeT     opcode,
  input  controlPkg::functT      funct,
  output logic                   resetOut,
  output logic                   pcWrite,
  output logic                   irWrite,
  output logic                   aluOutWrite,
  output logic                   regFileWrite,
  output logic                   aRegWrite,
  output logic                   bRegWrite,
  output controlPkg::pcSrcSelT   pcSrcSel,
  output controlPkg::regDstSelT  regDstSel,
  output controlPkg::regDataSelT regDataSel,
  output controlPkg::aluSrcSelT  aluSrcASel,
  output controlPkg::aluSrcSelT  aluSrcBSel,
  output controlPkg::aluOpT      aluOp
);

  controlPkg::instrClassT instrClass;
  controlPkg::functT      latchedFunct;
  controlPkg::phaseT      nextPhase;
  controlPkg::stepT       nextStep;
  logic                   decodeStrobe;

  instrClassRegister uInstrClassRegister (
    .clk          (clk),
    .reset_in     (reset_in),
    .decodeStrobe (decodeStrobe),
    .opcode       (opcode),
    .funct        (funct),
    .instrClass   (instrClass),
    .latchedFunct (latchedFunct)
  );

  // Current phase and step stay inside the sequencer
  microSequencer #(
    .memWaitCycles   (memWaitCycles),
    .shiftWaitCycles (shiftWaitCycles)
  ) uMicroSequencer (
    .clk          (clk),
    .reset_in     (reset_in),
    .instrClass   (instrClass),
    .phase        (),
    .step         (),
    .nextPhase    (nextPhase),
    .nextStep     (nextStep),
    .decodeStrobe (decodeStrobe)
  );

  controlSignalRegister #(
    .shiftWaitCycles (shiftWaitCycles)
  ) uControlSignalRegister (
    .clk          (clk),
    .reset_in     (reset_in),
    .nextPhase    (nextPhase),
    .nextStep     (nextStep),
    .instrClass   (instrClass),
    .latchedFunct (latchedFunct),
    .resetOut     (resetOut),
    .pcWrite      (pcWrite),
    .irWrite      (irWrite),
    .aluOutWrite  (aluOutWrite),
    .regFileWrite (regFileWrite),
    .aRegWrite    (aRegWrite),
    .bRegWrite    (bRegWrite),
    .pcSrcSel     (pcSrcSel),
    .regDstSel    (regDstSel),
    .regDataSel   (regDataSel),
    .aluSrcASel   (aluSrcASel),
    .aluSrcBSel   (aluSrcBSel),
    .aluOp        (aluOp)
  );

endmodule

// ==== tb/controlModel.svh ====
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

localparam int fetchCycles = 2 + memWaitCycles;

controlPkg::phaseT      mPhase = controlPkg::phReset;
int                     mStep  = 0;
controlPkg::instrClassT mClass = controlPkg::clsNone;  // Class of the instruction in flight
controlPkg::functT      mFunct = '0;

logic eResetOut, ePcWrite, eIrWrite, eAluOutWrite;
logic eRegFileWrite, eARegWrite, eBRegWrite;
controlPkg::pcSrcSelT   ePcSrc;
controlPkg::regDstSelT  eRegDst;
controlPkg::regDataSelT eRegData;
controlPkg::aluSrcSelT  eSrcA;
controlPkg::aluSrcSelT  eSrcB;
controlPkg::aluOpT      eAluOp;

function automatic controlPkg::instrClassT classify(input controlPkg::opcodeT op,
                                                    input controlPkg::functT fn);
  controlPkg::instrClassT cls;
  cls = controlPkg::clsNone;
  if (op == controlPkg::opJ) begin
    cls = controlPkg::clsJump;
  end else if (op == controlPkg::opJal) begin
    cls = controlPkg::clsJal;
  end else if (op == controlPkg::opR) begin
    case (fn)
      controlPkg::fnAdd:   cls = controlPkg::clsAluReg;
      controlPkg::fnAnd:   cls = controlPkg::clsAluReg;
      controlPkg::fnSub:   cls = controlPkg::clsAluReg;
      controlPkg::fnSlt:   cls = controlPkg::clsAluReg;
      controlPkg::fnSrav:  cls = controlPkg::clsShiftVar;
      controlPkg::fnSllv:  cls = controlPkg::clsShiftVar;
      controlPkg::fnSll:   cls = controlPkg::clsShiftImm;
      controlPkg::fnSra:   cls = controlPkg::clsShiftImm;
      controlPkg::fnSrl:   cls = controlPkg::clsShiftImm;
      controlPkg::fnJr:    cls = controlPkg::clsJr;
      controlPkg::fnMfhi:  cls = controlPkg::clsMoveHiLo;
      controlPkg::fnMflo:  cls = controlPkg::clsMoveHiLo;
      controlPkg::fnBreak: cls = controlPkg::clsBreak;
      controlPkg::fnRte:   cls = controlPkg::clsRte;
      default:             cls = controlPkg::clsNone;
    endcase
  end
  return cls;
endfunction

function automatic int execCycles(input controlPkg::instrClassT cls);
  case (cls)
    controlPkg::clsAluReg, controlPkg::clsShiftImm: return 5;
    controlPkg::clsJr, controlPkg::clsBreak:        return 5;
    controlPkg::clsShiftVar:                        return 5 + shiftWaitCycles;
    controlPkg::clsMoveHiLo, controlPkg::clsJal:    return 2;
    default:                                        return 0;
  endcase
endfunction

function automatic int regWriteCount(input controlPkg::instrClassT cls);
  case (cls)
    controlPkg::clsAluReg, controlPkg::clsShiftVar, controlPkg::clsShiftImm: return 1;
    controlPkg::clsMoveHiLo, controlPkg::clsJal:                             return 1;
    default:                                                                 return 0;
  endcase
endfunction

function automatic int pcWriteCount(input controlPkg::instrClassT cls);
  if (cls == controlPkg::clsJr || cls == controlPkg::clsBreak) return 2;
  return 1;
endfunction

function automatic controlPkg::aluOpT functOp(input controlPkg::functT fn);
  case (fn)
    controlPkg::fnAdd:  return controlPkg::aluAdd;
    controlPkg::fnAnd:  return controlPkg::aluAnd;
    controlPkg::fnSub:  return controlPkg::aluSub;
    controlPkg::fnSlt:  return controlPkg::aluSlt;
    controlPkg::fnSrav: return controlPkg::aluShiftRa2;
    controlPkg::fnSllv: return controlPkg::aluShiftL2;
    controlPkg::fnSll:  return controlPkg::aluShiftL1;
    controlPkg::fnSra:  return controlPkg::aluShiftRa1;
    controlPkg::fnSrl:  return controlPkg::aluShiftR;
    default:            return controlPkg::aluPassA;
  endcase
endfunction

task computeExpected();
  eResetOut     = 1'b0;
  ePcWrite      = 1'b0;
  eIrWrite      = 1'b0;
  eAluOutWrite  = 1'b0;
  eRegFileWrite = 1'b0;
  eARegWrite    = 1'b0;
  eBRegWrite    = 1'b0;
  ePcSrc        = controlPkg::pcFromAlu;
  eRegDst       = controlPkg::dstRt;
  eRegData      = controlPkg::dataAluOut;
  eSrcA         = controlPkg::srcPcOrB;
  eSrcB         = controlPkg::srcPcOrB;
  eAluOp        = controlPkg::aluPassA;
  case (mPhase)
    controlPkg::phReset: eResetOut = 1'b1;
    controlPkg::phFetch: begin
      if (mStep == fetchCycles - 1) begin
        ePcWrite = 1'b1;
        case (mClass)
          controlPkg::clsJump, controlPkg::clsJal: ePcSrc = controlPkg::pcFromJump;
          controlPkg::clsRte:                      ePcSrc = controlPkg::pcFromEpc;
          default:                                 ePcSrc = controlPkg::pcFromAluOut;
        endcase
        if (mClass == controlPkg::clsMoveHiLo) begin
          eRegFileWrite = 1'b1;
          eRegDst       = controlPkg::dstRd;
          if (mFunct == controlPkg::fnMfhi) eRegData = controlPkg::dataHi;
          else                              eRegData = controlPkg::dataLo;
        end
        if (mClass == controlPkg::clsJal) eRegDst = controlPkg::dstRa;
      end else begin
        eIrWrite     = (mStep == 0);
        eAluOutWrite = (mStep == 0);
        eSrcB        = controlPkg::srcRegOrFour;
        eAluOp       = controlPkg::aluAdd;
        ePcSrc       = controlPkg::pcFromAluOut;
      end
    end
    controlPkg::phExecute: begin
      case (mClass)
        controlPkg::clsAluReg, controlPkg::clsShiftVar, controlPkg::clsShiftImm: begin
          eRegDst    = controlPkg::dstRd;
          eARegWrite = (mStep == 0) && (mClass != controlPkg::clsShiftImm);
          eBRegWrite = (mStep == 0);
          if (mStep != 0) begin
            eAluOp = functOp(mFunct);
            if (mClass != controlPkg::clsShiftImm) eSrcA = controlPkg::srcRegOrFour;
          end
          if (mClass == controlPkg::clsShiftVar) eRegFileWrite = (mStep == 2 + shiftWaitCycles);
          else                                   eRegFileWrite = (mStep == 2);
        end
        controlPkg::clsJr: begin
          eRegDst    = controlPkg::dstRd;
          eARegWrite = (mStep == 0);
          if (mStep != 0) eSrcA = controlPkg::srcRegOrFour;
          ePcWrite   = (mStep == 2);  // From the ALU, select 00
        end
        controlPkg::clsBreak: begin
          eRegDst      = controlPkg::dstRd;
          eSrcB        = controlPkg::srcRegOrFour;
          eAluOp       = controlPkg::aluSub;
          ePcSrc       = controlPkg::pcFromAluOut;
          eAluOutWrite = (mStep == 0);
          ePcWrite     = (mStep == 2);
        end
        controlPkg::clsMoveHiLo: eRegDst = controlPkg::dstRd;
        controlPkg::clsJal: begin
          eRegDst       = controlPkg::dstRa;
          eRegFileWrite = (mStep == 0);
        end
        default: ;
      endcase
    end
    default: ;
  endcase
endtask

// Next phase and step, as seen after the coming edge
task advanceModel();
  if (reset_in) begin
    mPhase = controlPkg::phReset;
    mStep  = 0;
  end else begin
    case (mPhase)
      controlPkg::phReset: begin
        if (mStep == 0) begin
          mStep = 1;
        end else begin
          mPhase = controlPkg::phFetch;
          mStep  = 0;
        end
      end
      controlPkg::phFetch: begin
        if (mStep == fetchCycles - 1) begin
          mStep = 0;
          if (execCycles(mClass) != 0) mPhase = controlPkg::phExecute;
        end else begin
          mStep++;
        end
      end
      default: begin
        if (mStep == execCycles(mClass) - 1) begin
          mPhase = controlPkg::phFetch;
          mStep  = 0;
        end else begin
          mStep++;
        end
      end
    endcase
  end
endtask

`endif

// ==== tb/tb_controlUnit.sv ====
`timescale 1ns/1ps

module tb_controlUnit;

  localparam int memWaitCycles   = 1;
  localparam int shiftWaitCycles = 1;
  localparam int numInstr        = 400;
  localparam int irTimeout       = 40;

  localparam controlPkg::functT keptFuncts [14] = '{
    controlPkg::fnAdd, controlPkg::fnAnd, controlPkg::fnSub, controlPkg::fnSlt,
    controlPkg::fnSrav, controlPkg::fnSllv, controlPkg::fnSll, controlPkg::fnSra,
    controlPkg::fnSrl, controlPkg::fnJr, controlPkg::fnMfhi, controlPkg::fnMflo,
    controlPkg::fnRte, controlPkg::fnBreak
  };

  logic                   clk;
  logic                   reset_in;
  controlPkg::opcodeT     opcode;
  controlPkg::functT      funct;
  logic                   resetOut, pcWrite, irWrite, aluOutWrite;
  logic                   regFileWrite, aRegWrite, bRegWrite;
  controlPkg::pcSrcSelT   pcSrcSel;
  controlPkg::regDstSelT  regDstSel;
  controlPkg::regDataSelT regDataSel;
  controlPkg::aluSrcSelT  aluSrcASel;
  controlPkg::aluSrcSelT  aluSrcBSel;
  controlPkg::aluOpT      aluOp;

  int unsigned seedValue;
  logic        drawPending;
  int          regWrites;
  int          pcWrites;

  controlUnit #(
    .memWaitCycles   (memWaitCycles),
    .shiftWaitCycles (shiftWaitCycles)
  ) u_controlUnit (
    .clk          (clk),
    .reset_in     (reset_in),
    .opcode       (opcode),
    .funct        (funct),
    .resetOut     (resetOut),
    .pcWrite      (pcWrite),
    .irWrite      (irWrite),
    .aluOutWrite  (aluOutWrite),
    .regFileWrite (regFileWrite),
    .aRegWrite    (aRegWrite),
    .bRegWrite    (bRegWrite),
    .pcSrcSel     (pcSrcSel),
    .regDstSel    (regDstSel),
    .regDataSel   (regDataSel),
    .aluSrcASel   (aluSrcASel),
    .aluSrcBSel   (aluSrcBSel),
    .aluOp        (aluOp)
  );

  `include "controlModel.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stopRun();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkAluOp(input string name, input controlPkg::aluOpT got,
                            input controlPkg::aluOpT exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkPcSrc(input string name, input controlPkg::pcSrcSelT got,
                            input controlPkg::pcSrcSelT exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkRegDst(input string name, input controlPkg::regDstSelT got,
                             input controlPkg::regDstSelT exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkRegData(input string name, input controlPkg::regDataSelT got,
                              input controlPkg::regDataSelT exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkAluSrc(input string name, input controlPkg::aluSrcSelT got,
                             input controlPkg::aluSrcSelT exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  // Mostly kept instructions, the rest random pairs
  task automatic drawInstruction();
    int unsigned pick;
    pick = $urandom_range(0, 99);
    if (pick < 85) begin
      pick  = $urandom_range(0, 15);
      funct = 6'($urandom_range(0, 63));
      if (pick == 14) begin
        opcode = controlPkg::opJ;
      end else if (pick == 15) begin
        opcode = controlPkg::opJal;
      end else begin
        opcode = controlPkg::opR;
        funct  = keptFuncts[pick];
      end
    end else begin
      opcode = 6'($urandom_range(0, 63));
      funct  = 6'($urandom_range(0, 63));
    end
  endtask

  task automatic runCycle(input logic resetNext);
    @(posedge clk);
    #1;
    computeExpected();
    checkFlag("resetOut", resetOut, eResetOut);
    checkFlag("pcWrite", pcWrite, ePcWrite);
    checkFlag("irWrite", irWrite, eIrWrite);
    checkFlag("aluOutWrite", aluOutWrite, eAluOutWrite);
    checkFlag("regFileWrite", regFileWrite, eRegFileWrite);
    checkFlag("aRegWrite", aRegWrite, eARegWrite);
    checkFlag("bRegWrite", bRegWrite, eBRegWrite);
    checkPcSrc("pcSrcSel", pcSrcSel, ePcSrc);
    checkRegDst("regDstSel", regDstSel, eRegDst);
    checkRegData("regDataSel", regDataSel, eRegData);
    checkAluSrc("aluSrcASel", aluSrcASel, eSrcA);
    checkAluSrc("aluSrcBSel", aluSrcBSel, eSrcB);
    checkAluOp("aluOp", aluOp, eAluOp);
    if (regFileWrite) regWrites++;
    if (pcWrite) pcWrites++;
    if (drawPending) begin
      drawInstruction();
      drawPending = 1'b0;
    end
    if (mPhase == controlPkg::phFetch && mStep == 0) begin
      mClass      = classify(opcode, funct);  // DUT latches at the end of this cycle
      mFunct      = funct;
      drawPending = 1'b1;
    end
    reset_in = resetNext;
    advanceModel();
  endtask

  task automatic waitForIrWrite(output int cycles);
    cycles = 0;
    do begin
      runCycle(1'b0);
      cycles++;
      if (!irWrite && cycles >= irTimeout) begin
        $display("Timeout: no irWrite pulse within %0d cycles", irTimeout);
        stopRun();
      end
    end while (!irWrite);
  endtask

  initial begin
    int cycles;
    controlPkg::instrClassT prevClass;
    seedValue   = $urandom(32'hc664_819c);
    reset_in    = 1'b1;
    drawPending = 1'b0;
    regWrites   = 0;
    pcWrites    = 0;
    drawInstruction();
    repeat (3) runCycle(1'b1);
    runCycle(1'b0);  // Reset seen low from the fifth edge
    waitForIrWrite(cycles);
    checkCount("cycles to first irWrite", cycles, 2);
    for (int n = 0; n < numInstr; n++) begin
      prevClass = mClass;
      regWrites = 0;
      pcWrites  = 0;
      waitForIrWrite(cycles);
      checkCount("irWrite interval", cycles, fetchCycles + execCycles(prevClass));
      checkCount("regFileWrite pulses", regWrites, regWriteCount(prevClass));
      checkCount("pcWrite pulses", pcWrites, pcWriteCount(prevClass));
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+tb
src/controlPkg.sv
src/instrClassRegister.sv
src/microSequencer.sv
src/controlSignalRegister.sv
src/controlUnit.sv
tb/tb_controlUnit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_controlUnit
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# Result decided by the pass line in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
